// File: hw/axi_host_port.sv
`timescale 1ns/1ps

module axi_host_port import irq_pkg::*; (
  input  logic       aclk,
  input  logic       arst_n,
  // Engine side
  input  logic       rd_req,
  input  addr_t      rd_addr,
  input  axi_id_t    req_id,
  output logic       rd_done,
  output data_t      rd_data,
  output logic       rd_err,
  input  logic       wr_req,
  input  addr_t      wr_addr,
  input  data_t      wr_data,
  output logic       wr_done,
  output logic       wr_err,
  // AXI3 read address
  output axi_id_t    arid,
  output addr_t      araddr,
  output logic [7:0] arlen,
  output logic [2:0] arsize,
  output logic [1:0] arburst,
  output logic [1:0] arlock,
  output logic [3:0] arcache,
  output logic [2:0] arprot,
  output logic       arvalid,
  input  logic       arready,
  // AXI3 read data
  input  axi_id_t    rid,
  input  data_t      rdata,
  input  axi_resp_t  rresp,
  input  logic       rlast,
  input  logic       rvalid,
  output logic       rready,
  // AXI3 write address
  output axi_id_t    awid,
  output addr_t      awaddr,
  output logic [7:0] awlen,
  output logic [2:0] awsize,
  output logic [1:0] awburst,
  output logic [1:0] awlock,
  output logic [3:0] awcache,
  output logic [2:0] awprot,
  output logic       awvalid,
  input  logic       awready,
  // AXI3 write data
  output axi_id_t    wid,
  output data_t      wdata,
  output logic [3:0] wstrb,
  output logic       wlast,
  output logic       wvalid,
  input  logic       wready,
  // AXI3 write response
  input  axi_id_t    bid,
  input  axi_resp_t  bresp,
  input  logic       bvalid,
  output logic       bready
);

  localparam logic [7:0] LEN_SINGLE = 8'd0;
  localparam logic [2:0] SIZE_4B    = 3'd2;
  localparam logic [1:0] BURST_INCR = 2'b01;

  logic    rd_busy;
  logic    wr_busy;
  logic    rd_start;
  logic    wr_start;
  logic    r_hs;
  logic    b_hs;
  addr_t   ar_addr_q;
  axi_id_t ar_id_q;
  addr_t   aw_addr_q;
  axi_id_t aw_id_q;
  data_t   w_data_q;
  axi_id_t wid_q;   // Id last sent on AW

  assign rd_start = rd_req && !rd_busy;
  assign wr_start = wr_req && !wr_busy;
  assign r_hs     = rvalid && rready;
  assign b_hs     = bvalid && bready;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      rd_busy <= 1'b0;
      arvalid <= 1'b0;
      wr_busy <= 1'b0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
    end else begin
      if (rd_start) begin
        rd_busy <= 1'b1;
        arvalid <= 1'b1;
      end else begin
        if (arvalid && arready) begin
          arvalid <= 1'b0;
        end
        if (r_hs) begin
          rd_busy <= 1'b0;
        end
      end
      if (wr_start) begin
        wr_busy <= 1'b1;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
      end else begin
        if (awvalid && awready) begin
          awvalid <= 1'b0;
        end
        if (wvalid && wready) begin
          wvalid <= 1'b0;
        end
        if (b_hs) begin
          wr_busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_start) begin
      ar_addr_q <= rd_addr;
      ar_id_q   <= req_id;
    end
    if (wr_start) begin
      aw_addr_q <= wr_addr;
      aw_id_q   <= req_id;
      w_data_q  <= wr_data;
    end
    if (awvalid) begin
      wid_q <= awid;
    end
  end

  assign arid    = ar_id_q;
  assign araddr  = ar_addr_q;
  assign arlen   = LEN_SINGLE;
  assign arsize  = SIZE_4B;
  assign arburst = BURST_INCR;
  assign arlock  = 2'b00;
  assign arcache = 4'd0;
  assign arprot  = 3'd0;
  assign rready  = rd_busy && !arvalid;

  assign awid    = aw_id_q;
  assign awaddr  = aw_addr_q;
  assign awlen   = LEN_SINGLE;
  assign awsize  = SIZE_4B;
  assign awburst = BURST_INCR;
  assign awlock  = 2'b00;
  assign awcache = 4'd0;
  assign awprot  = 3'd0;

  assign wid     = awvalid ? awid : wid_q;
  assign wdata   = w_data_q;
  assign wstrb   = 4'hF;
  assign wlast   = 1'b1;
  assign bready  = wr_busy && !awvalid && !wvalid;   // Both AW and W accepted

  assign rd_done = r_hs;
  assign rd_data = rdata;
  assign rd_err  = !(rresp == RESP_OKAY || rresp == RESP_EXOKAY);
  assign wr_done = b_hs;
  assign wr_err  = !(bresp == RESP_OKAY || bresp == RESP_EXOKAY);

  ar_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    arvalid && !arready |=> arvalid && $stable(araddr));

  // Slave must answer single beats with the id it was given
  r_match: assert property (@(posedge aclk) disable iff (!arst_n)
    r_hs |-> rlast && rid == ar_id_q);

  b_match: assert property (@(posedge aclk) disable iff (!arst_n)
    b_hs |-> bid == aw_id_q);

endmodule

// File: hw/core_top.sv
`timescale 1ns/1ps

module core_top import irq_pkg::*; #(
  parameter int    N_IRQ      = 8,
  parameter addr_t COUNT_BASE = 32'h0000_1000
) (
  input  logic             aclk,
  input  logic             arst_n,
  input  logic [N_IRQ-1:0] intrpt,
  // Read request
  output axi_id_t          arid,
  output addr_t            araddr,
  output logic [7:0]       arlen,
  output logic [2:0]       arsize,
  output logic [1:0]       arburst,
  output logic [1:0]       arlock,
  output logic [3:0]       arcache,
  output logic [2:0]       arprot,
  output logic             arvalid,
  input  logic             arready,
  // Read data
  input  axi_id_t          rid,
  input  data_t            rdata,
  input  axi_resp_t        rresp,
  input  logic             rlast,
  input  logic             rvalid,
  output logic             rready,
  // Write request
  output axi_id_t          awid,
  output addr_t            awaddr,
  output logic [7:0]       awlen,
  output logic [2:0]       awsize,
  output logic [1:0]       awburst,
  output logic [1:0]       awlock,
  output logic [3:0]       awcache,
  output logic [2:0]       awprot,
  output logic             awvalid,
  input  logic             awready,
  // Write data
  output axi_id_t          wid,
  output data_t            wdata,
  output logic [3:0]       wstrb,
  output logic             wlast,
  output logic             wvalid,
  input  logic             wready,
  // Write response
  input  axi_id_t          bid,
  input  axi_resp_t        bresp,
  input  logic             bvalid,
  output logic             bready,
  // Counter update report
  output addr_t            debug0_wb_pc,
  output logic [3:0]       debug0_wb_rf_wen,
  output logic [4:0]       debug0_wb_rf_wnum,
  output data_t            debug0_wb_rf_wdata
);

  logic    grant_valid;
  line_t   grant_line;
  logic    grant_take;
  logic    rd_req;
  addr_t   rd_addr;
  axi_id_t req_id;
  logic    rd_done;
  data_t   rd_data;
  logic    rd_err;
  logic    wr_req;
  addr_t   wr_addr;
  data_t   wr_data;
  logic    wr_done;
  logic    wr_err;

  irq_capture #(
    .N_IRQ(N_IRQ)
  ) i_capture (
    .aclk(aclk),
    .arst_n(arst_n),
    .intrpt(intrpt),
    .grant_take(grant_take),
    .grant_valid(grant_valid),
    .grant_line(grant_line)
  );

  count_engine #(
    .N_IRQ(N_IRQ),
    .COUNT_BASE(COUNT_BASE)
  ) i_engine (
    .aclk(aclk),
    .arst_n(arst_n),
    .grant_valid(grant_valid),
    .grant_line(grant_line),
    .grant_take(grant_take),
    .rd_req(rd_req),
    .rd_addr(rd_addr),
    .req_id(req_id),
    .rd_done(rd_done),
    .rd_data(rd_data),
    .rd_err(rd_err),
    .wr_req(wr_req),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .wr_done(wr_done),
    .wr_err(wr_err),
    .wb_pc(debug0_wb_pc),
    .wb_wen(debug0_wb_rf_wen),
    .wb_wnum(debug0_wb_rf_wnum),
    .wb_wdata(debug0_wb_rf_wdata)
  );

  // Engine requests and every AXI3 port connect by matching names
  axi_host_port i_host_port (.*);

endmodule

// File: hw/count_engine.sv
`timescale 1ns/1ps

module count_engine import irq_pkg::*; #(
  parameter int    N_IRQ      = 8,
  parameter addr_t COUNT_BASE = 32'h0000_1000
) (
  input  logic          aclk,
  input  logic          arst_n,
  // Pending line selection
  input  logic          grant_valid,
  input  line_t         grant_line,
  output logic          grant_take,
  // Read request
  output logic          rd_req,
  output addr_t         rd_addr,
  output axi_id_t       req_id,
  input  logic          rd_done,
  input  data_t         rd_data,
  input  logic          rd_err,
  // Write request
  output logic          wr_req,
  output addr_t         wr_addr,
  output data_t         wr_data,
  input  logic          wr_done,
  input  logic          wr_err,
  // Debug report
  output addr_t         wb_pc,
  output logic [3:0]    wb_wen,
  output logic [4:0]    wb_wnum,
  output data_t         wb_wdata
);

  engine_state_t state;
  line_t         line_q;
  data_t         value_q;   // Incremented counter value
  addr_t         count_addr;

  assign count_addr = COUNT_BASE + {27'd0, line_q, 2'b00};

  assign grant_take = (state == ST_IDLE) && grant_valid;

  assign rd_req  = (state == ST_READ);
  assign rd_addr = count_addr;
  assign req_id  = {1'b0, line_q};

  assign wr_req  = (state == ST_WRITE);
  assign wr_addr = count_addr;
  assign wr_data = value_q;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      wb_pc    <= '0;
      wb_wen   <= '0;
      wb_wnum  <= '0;
      wb_wdata <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (grant_valid) begin
            state <= ST_READ;
          end
        end
        ST_READ: begin
          if (rd_done) begin
            state <= rd_err ? ST_IDLE : ST_WRITE;   // Bad read drops the event
          end
        end
        ST_WRITE: begin
          if (wr_done && wr_err) begin
            state <= ST_IDLE;
          end else if (wr_done) begin
            state    <= ST_REPORT;
            wb_pc    <= count_addr;
            wb_wen   <= 4'hF;
            wb_wnum  <= {2'b00, line_q};
            wb_wdata <= value_q;
          end
        end
        ST_REPORT: begin
          state    <= ST_IDLE;
          wb_pc    <= '0;
          wb_wen   <= '0;
          wb_wnum  <= '0;
          wb_wdata <= '0;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (grant_take) begin
      line_q <= grant_line;
    end
    if (rd_done && !rd_err) begin
      value_q <= rd_data + 32'd1;
    end
  end

  req_exclusive: assert property (@(posedge aclk) disable iff (!arst_n)
    !(rd_req && wr_req));

  // Address must hold for the whole read, the host port may resample it
  rd_addr_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    rd_req |=> !rd_req || $stable(rd_addr));

  line_in_range: assert property (@(posedge aclk) disable iff (!arst_n)
    grant_take |-> int'(grant_line) < N_IRQ);

endmodule

// File: hw/irq_capture.sv
`timescale 1ns/1ps

module irq_capture import irq_pkg::*; #(
  parameter int N_IRQ = 8
) (
  input  logic             aclk,
  input  logic             arst_n,
  input  logic [N_IRQ-1:0] intrpt,
  input  logic             grant_take,
  output logic             grant_valid,
  output line_t            grant_line
);

  logic [N_IRQ-1:0] sync_q1;
  logic [N_IRQ-1:0] sync_q2;
  logic [N_IRQ-1:0] level_q;   // Previous synchronized level
  logic [N_IRQ-1:0] rise;
  logic [N_IRQ-1:0] take_mask;
  logic [N_IRQ-1:0] pending;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      level_q <= '0;
    end else begin
      sync_q1 <= intrpt;
      sync_q2 <= sync_q1;
      level_q <= sync_q2;
    end
  end

  assign rise = sync_q2 & ~level_q;

  always_comb begin
    take_mask = '0;
    if (grant_take) begin
      take_mask[grant_line] = 1'b1;
    end
  end

  // A fresh edge overrides the clear of the line being taken
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~take_mask) | rise;
    end
  end

  // Lowest index wins
  always_comb begin
    grant_line = '0;
    for (int i = N_IRQ - 1; i >= 0; i--) begin
      if (pending[i]) begin
        grant_line = line_t'(i);
      end
    end
  end

  assign grant_valid = |pending;

  take_needs_valid: assert property (@(posedge aclk) disable iff (!arst_n)
    grant_take |-> grant_valid);

endmodule

// File: hw/irq_pkg.sv
package irq_pkg;

  // Bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  axi_id_t;
  typedef logic [1:0]  axi_resp_t;

  // Interrupt line number, also used as the AXI id
  typedef logic [2:0]  line_t;

  // AXI response codes
  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_EXOKAY = 2'b01;
  localparam axi_resp_t RESP_SLVERR = 2'b10;
  localparam axi_resp_t RESP_DECERR = 2'b11;

  typedef enum logic [1:0] {
    ST_IDLE,    // Waiting for a pending line
    ST_READ,    // Counter read in flight
    ST_WRITE,   // Incremented value being written back
    ST_REPORT   // One-cycle debug report
  } engine_state_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the interrupt counter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_core_top \
  -f sim.f \
  -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

echo "Simulation ended normally"
exit 0

// File: sim.f
hw/irq_pkg.sv
hw/irq_capture.sv
hw/count_engine.sv
hw/axi_host_port.sv
hw/core_top.sv
tb/axi_mem_model.sv
tb/tb_core_top.sv

// File: tb/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model import irq_pkg::*; (
  input  logic      aclk,
  input  logic      arst_n,
  input  addr_t     err_addr,   // Answered with SLVERR
  // Backdoor preset port
  input  logic      pre_en,
  input  addr_t     pre_addr,
  input  data_t     pre_data,
  // AXI3 slave side, single beats only
  input  axi_id_t   arid,
  input  addr_t     araddr,
  input  logic      arvalid,
  output logic      arready,
  output axi_id_t   rid,
  output data_t     rdata,
  output axi_resp_t rresp,
  output logic      rlast,
  output logic      rvalid,
  input  logic      rready,
  input  axi_id_t   awid,
  input  addr_t     awaddr,
  input  logic      awvalid,
  output logic      awready,
  input  data_t     wdata,
  input  logic      wvalid,
  output logic      wready,
  output axi_id_t   bid,
  output axi_resp_t bresp,
  output logic      bvalid,
  input  logic      bready
);

  data_t      mem [0:255];
  integer     seed = 20;
  logic [1:0] ar_wait;
  logic [1:0] aw_wait;
  logic [1:0] w_wait;
  logic       aw_got;
  logic       w_got;
  addr_t      aw_addr_q;
  axi_id_t    aw_id_q;
  data_t      w_data_q;
  logic       do_write;

  assign rlast    = 1'b1;
  assign do_write = aw_got && w_got && !bvalid && (aw_addr_q != err_addr);

  always @(posedge aclk) begin
    if (pre_en) begin
      mem[pre_addr[9:2]] <= pre_data;
    end else if (do_write) begin
      mem[aw_addr_q[9:2]] <= w_data_q;
    end
  end

  always @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rid     <= '0;
      rdata   <= '0;
      rresp   <= RESP_OKAY;
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      bid     <= '0;
      bresp   <= RESP_OKAY;
      ar_wait <= '0;
      aw_wait <= '0;
      w_wait  <= '0;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
    end else begin
      // Ready rises after a random wait of 0 to 3 cycles
      if (arvalid && arready) begin
        arready <= 1'b0;
        ar_wait <= 2'($random(seed));
        rvalid  <= 1'b1;
        rid     <= arid;
        rdata   <= mem[araddr[9:2]];
        rresp   <= (araddr == err_addr) ? RESP_SLVERR : RESP_OKAY;
      end else if (arvalid && !rvalid) begin
        if (ar_wait == 2'd0) begin
          arready <= 1'b1;
        end else begin
          ar_wait <= ar_wait - 2'd1;
        end
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end

      if (awvalid && awready) begin
        awready   <= 1'b0;
        aw_wait   <= 2'($random(seed));
        aw_got    <= 1'b1;
        aw_addr_q <= awaddr;
        aw_id_q   <= awid;
      end else if (awvalid && !aw_got) begin
        if (aw_wait == 2'd0) begin
          awready <= 1'b1;
        end else begin
          aw_wait <= aw_wait - 2'd1;
        end
      end

      if (wvalid && wready) begin
        wready   <= 1'b0;
        w_wait   <= 2'($random(seed));
        w_got    <= 1'b1;
        w_data_q <= wdata;
      end else if (wvalid && !w_got) begin
        if (w_wait == 2'd0) begin
          wready <= 1'b1;
        end else begin
          w_wait <= w_wait - 2'd1;
        end
      end

      // B goes out once address and data are both in
      if (aw_got && w_got && !bvalid) begin
        bvalid <= 1'b1;
        bid    <= aw_id_q;
        bresp  <= (aw_addr_q == err_addr) ? RESP_SLVERR : RESP_OKAY;
        aw_got <= 1'b0;
        w_got  <= 1'b0;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

endmodule

// File: tb/tb_core_top.sv
`timescale 1ns/1ps

module tb_core_top import irq_pkg::*; ();

  localparam addr_t COUNT_BASE = 32'h0000_1000;
  localparam int    MAX_CYCLES = 20000;   // About 16 reports, 200 idle cycles and pulse gaps

  logic       aclk;
  logic       arst_n;
  logic [7:0] intrpt;
  axi_id_t    arid, rid, awid, wid, bid;
  addr_t      araddr, awaddr, err_addr, pre_addr;
  data_t      rdata, wdata, pre_data;
  logic [7:0] arlen, awlen;
  logic [2:0] arsize, arprot, awsize, awprot;
  logic [1:0] arburst, arlock, awburst, awlock;
  logic [3:0] arcache, awcache, wstrb;
  axi_resp_t  rresp, bresp;
  logic       arvalid, arready, rlast, rvalid, rready;
  logic       awvalid, awready, wlast, wvalid, wready, bvalid, bready;
  logic       pre_en;
  addr_t      debug0_wb_pc;
  logic [3:0] debug0_wb_rf_wen;
  logic [4:0] debug0_wb_rf_wnum;
  data_t      debug0_wb_rf_wdata;

  data_t ref_count [0:7];   // Expected counter per line
  int    cycles = 0;

  core_top #(
    .N_IRQ(8),
    .COUNT_BASE(COUNT_BASE)
  ) i_dut (.*);

  axi_mem_model i_mem (.*);

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $fatal(1, "Simulation timed out");
    end
  end

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "Check failed");
  endtask

  function automatic addr_t counter_addr(input int line);
    return COUNT_BASE + addr_t'(line * 4);
  endfunction

  function automatic data_t mem_word(input int line);
    addr_t a;
    a = counter_addr(line);
    return i_mem.mem[a[9:2]];
  endfunction

  // Fixed single-beat fields, full strobes, id = line number, wid follows awid
  always @(posedge aclk) begin
    if (arst_n) begin
      if (arvalid) begin
        assert (arlen == 8'd0) else report_fail($sformatf("arlen %0d", arlen));
        assert (arsize == 3'd2 && arburst == 2'b01)
          else report_fail($sformatf("arsize %0d, arburst %0d", arsize, arburst));
        assert (arlock == 2'b00 && arcache == 4'd0 && arprot == 3'd0)
          else report_fail($sformatf("arlock %0d, arcache %0d, arprot %0d",
                                     arlock, arcache, arprot));
        assert (arid == axi_id_t'((araddr - COUNT_BASE) >> 2))
          else report_fail($sformatf("arid %0d for araddr %h", arid, araddr));
      end
      if (awvalid) begin
        assert (awlen == 8'd0) else report_fail($sformatf("awlen %0d", awlen));
        assert (awsize == 3'd2 && awburst == 2'b01)
          else report_fail($sformatf("awsize %0d, awburst %0d", awsize, awburst));
        assert (awlock == 2'b00 && awcache == 4'd0 && awprot == 3'd0)
          else report_fail($sformatf("awlock %0d, awcache %0d, awprot %0d",
                                     awlock, awcache, awprot));
        assert (awid == axi_id_t'((awaddr - COUNT_BASE) >> 2))
          else report_fail($sformatf("awid %0d for awaddr %h", awid, awaddr));
      end
      if (wvalid && wready) begin
        assert (wstrb == 4'hF) else report_fail($sformatf("wstrb %h", wstrb));
        assert (wlast == 1'b1) else report_fail($sformatf("wlast %0b", wlast));
        assert (wid == awid) else report_fail($sformatf("wid %0d, awid %0d", wid, awid));
      end
    end
  end

  task automatic preset_counter(input int line, input data_t value);
    @(posedge aclk);
    pre_en   <= 1'b1;
    pre_addr <= counter_addr(line);
    pre_data <= value;
    @(posedge aclk);
    pre_en <= 1'b0;
    ref_count[line] = value;
  endtask

  task automatic pulse_lines(input logic [7:0] mask);
    @(posedge aclk);
    intrpt <= mask;
    repeat (2) @(posedge aclk);
    intrpt <= '0;
  endtask

  task automatic expect_report(input int line);
    data_t expected;
    expected = ref_count[line] + 32'd1;
    ref_count[line] = expected;
    @(posedge aclk);
    while (debug0_wb_rf_wen == 4'h0) @(posedge aclk);
    assert (debug0_wb_rf_wen == 4'hF)
      else report_fail($sformatf("wen %h, expected f", debug0_wb_rf_wen));
    assert (debug0_wb_rf_wnum == 5'(line))
      else report_fail($sformatf("wnum %0d, expected %0d", debug0_wb_rf_wnum, line));
    assert (debug0_wb_pc == counter_addr(line))
      else report_fail($sformatf("pc %h, expected %h", debug0_wb_pc, counter_addr(line)));
    assert (debug0_wb_rf_wdata == expected)
      else report_fail($sformatf("wdata %0d, expected %0d", debug0_wb_rf_wdata, expected));
    assert (mem_word(line) == expected)
      else report_fail($sformatf("memory holds %0d, expected %0d", mem_word(line), expected));
  endtask

  task automatic test_single_pulse();
    pulse_lines(8'h08);
    expect_report(3);   // 41 becomes 42 at 32'h100C
  endtask

  task automatic test_same_cycle();
    pulse_lines(8'h62);
    expect_report(1);
    expect_report(5);
    expect_report(6);
  endtask

  task automatic test_repeated_pulses();
    for (int n = 0; n < 10; n++) begin
      pulse_lines(8'h01);
      expect_report(0);
      repeat (20) @(posedge aclk);
    end
  endtask

  task automatic test_edge_during_service();
    pulse_lines(8'h04);
    while (!(arvalid && arid == 4'd2)) @(posedge aclk);
    pulse_lines(8'h04);
    expect_report(2);
    expect_report(2);
  endtask

  task automatic test_read_error();
    @(posedge aclk);
    err_addr <= counter_addr(4);
    pulse_lines(8'h10);
    while (!(arvalid && arid == 4'd4)) @(posedge aclk);
    repeat (200) begin
      @(posedge aclk);
      assert (!awvalid)
        else report_fail("write request issued for line 4 after its read failed");
      assert (debug0_wb_rf_wen == 4'h0)
        else report_fail("report seen for line 4 after its read failed");
    end
    pulse_lines(8'h80);
    expect_report(7);
  endtask

  initial begin
    intrpt   = '0;
    err_addr = 32'hFFFF_FFF0;   // Outside the counter block
    pre_en   = 1'b0;
    pre_addr = '0;
    pre_data = '0;
    arst_n   = 1'b0;
    repeat (5) @(posedge aclk);
    arst_n <= 1'b1;

    preset_counter(0, 32'd0);
    preset_counter(1, 32'd7);
    preset_counter(2, 32'd100);
    preset_counter(3, 32'd41);
    preset_counter(4, 32'd55);
    preset_counter(5, 32'd500);
    preset_counter(6, 32'hFFFF_FFFF);   // Wraps to 0
    preset_counter(7, 32'd1234);

    test_single_pulse();
    test_same_cycle();
    test_repeated_pulses();
    test_edge_during_service();
    test_read_error();

    repeat (5) @(posedge aclk);
    $display("Test passed");
    $finish;
  end

endmodule
